// File: tb/echo_input.txt
# kind (C char, B break, F framing error, T test start), byte sent hex, echo expected hex
# a T line gives the test number and then 1 for back to back frames
T 2 0
C 41 61
C 7A 5A
C 4D 6D
C 71 51
T 3 0
C 40 40
C 5B 5B
C 60 60
C 7B 7B
C 30 30
C 39 39
C 00 00
T 4 1
C 48 68
C 69 49
C 21 21
C 55 75
C 61 41
C 5A 7A
T 5 0
C 4F 6F
B 00 00
C 6B 4B
F A5 00
C 3F 3F
B 00 00
F 80 00
C 61 41

// File: tb.f
design/uart_pkg.sv
design/serial_rx.sv
design/rx_fifo.sv
design/echo_ctrl.sv
design/serial_tx.sv
design/uart_echo.sv
tb/tb_uart_echo.sv

// File: run.sh
#!/bin/sh
# build with verilator, run into sim.log, decide from the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_uart_echo -f tb.f -o tb_uart_echo \
  || { echo "verilator build failed"; exit 1; }
./obj_dir/tb_uart_echo > sim.log 2>&1
cat sim.log
grep -q "TESTS PASSED" sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// File: tb/tb_uart_echo.sv
`timescale 1ns/10ps

module tb_uart_echo import uart_pkg::*; ();

  localparam int          DRAIN_LIMIT = 20 * 10 * CLK_PER_BIT;  // about twenty frames
  localparam int          QUIET_BITS  = 12;                     // idle tail of each test
  localparam logic [31:0] LFSR_SEED   = 32'hc12b_0a7a;

  logic        clk;
  logic        rst;
  logic        rx;
  logic        tx;
  logic        brk;
  byte_t       exp_q[$];      // echoes still due on tx
  int          brk_pending;   // breaks still due on brk
  int          err_count;
  int          check_count;
  int          test_count;
  int          test_fails;
  int          test_err_base; // err_count at test start
  int          test_num;
  logic [31:0] lfsr;
  logic        tx_prev;       // tx monitor state
  logic        mon_active;
  int          mon_cnt;       // negedges since the start edge
  byte_t       mon_byte;

  uart_echo uart_echo_i (
    .clk (clk),
    .rst (rst),
    .rx  (rx),
    .tx  (tx),
    .brk (brk)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns
  end

  task automatic check_byte(input string name, input byte_t exp, input byte_t act);
    check_count++;
    if (act !== exp)
    begin
      err_count++;
      $display("ERROR at %0d ns: %s expected %02h, got %02h", $time, name, exp, act);
    end
  endtask

  task automatic check_brk(input logic exp, input logic act);
    check_count++;
    if (act !== exp)
    begin
      err_count++;
      $display("ERROR at %0d ns: brk expected %b, got %b", $time, exp, act);
    end
  endtask

  // line levels on tx
  task automatic check_level(input string name, input logic exp, input logic act);
    check_count++;
    if (act !== exp)
    begin
      err_count++;
      $display("ERROR at %0d ns: %s expected %b, got %b", $time, name, exp, act);
    end
  endtask

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic int pick_gap();
    int gap;
    gap = 0;
    for (int i = 0; i < 2; i++)
    begin
      lfsr = lfsr_next(lfsr);  // one step per bit taken
      gap  = gap * 2 + int'(lfsr[0]);
    end
    return gap;
  endfunction

  // one bit time, entered and left at posedge + 2 ns
  task automatic hold_bit(input logic b);
    rx = b;
    repeat (CLK_PER_BIT) @(posedge clk);
    #2;
  endtask

  task automatic idle_bits(input int n);
    repeat (n) hold_bit(1'b1);
  endtask

  task automatic send_frame(input byte_t data, input logic stop);
    hold_bit(1'b0);  // start
    for (int i = 0; i < 8; i++)
      hold_bit(data[i]);  // lsb first
    hold_bit(stop);
  endtask

  task automatic begin_test(input int n);
    test_num      = n;
    test_err_base = err_count;
  endtask

  task automatic report_test();
    test_count++;
    if (err_count == test_err_base)
      $display("test %0d ok", test_num);
    else
    begin
      test_fails++;
      $display("test %0d failed with %0d errors", test_num, err_count - test_err_base);
    end
  endtask

  // wait for all expected echoes and breaks
  task automatic end_test();
    int cycles;
    cycles = 0;
    while ((exp_q.size() != 0 || brk_pending != 0) && cycles < DRAIN_LIMIT)
    begin
      @(posedge clk);
      #2;
      cycles++;
    end
    if (exp_q.size() != 0 || brk_pending != 0)
    begin
      $display("timeout in test %0d: %0d echoes and %0d brk pulses never came",
               test_num, exp_q.size(), brk_pending);
      err_count++;
      exp_q.delete();
      brk_pending = 0;
    end
    idle_bits(QUIET_BITS);  // stray frames show up here
    report_test();
  endtask

  task automatic run_file();
    int         fd;
    int         n;
    int         gap;
    string      line;
    logic [7:0] kind;
    byte_t      data;
    byte_t      expd;
    logic       burst;
    burst = 1'b0;
    fd = $fopen("tb/echo_input.txt", "r");
    if (fd == 0)
    begin
      $display("could not open tb/echo_input.txt");
      err_count++;
      return;
    end
    while (!$feof(fd))
    begin
      if ($fgets(line, fd) == 0)
        break;
      if (line.len() < 5 || line[0] == "#")
        continue;  // blank or comment
      n = $sscanf(line, "%c %h %h", kind, data, expd);
      if (n != 3)
      begin
        $display("data file line could not be read: %s", line);
        err_count++;
      end
      else if (kind == "T")
      begin
        if (test_num > 1)
          end_test();
        begin_test(int'(data));
        burst = expd[0];  // 1 means back to back frames
      end
      else
      begin
        case (kind)
          "C":
          begin
            exp_q.push_back(expd);
            send_frame(data, 1'b1);
          end
          "B":
          begin
            brk_pending++;
            repeat (12) hold_bit(1'b0);  // break, twelve bit times low
          end
          "F": send_frame(data, 1'b0);  // low stop, nonzero data
          default:
          begin
            $display("unknown kind in data file: %s", line);
            err_count++;
          end
        endcase
        gap = burst ? 0 : pick_gap();
        if (kind != "C" && gap == 0)
          gap = 1;  // rx has to rise before the next start edge
        idle_bits(gap);
      end
    end
    $fclose(fd);
    if (test_num > 1)
      end_test();
  endtask

  // tx frames and brk pulses, sampled on the falling clock
  always @(negedge clk)
  begin
    if (rst)
    begin
      tx_prev    = 1'b1;
      mon_active = 1'b0;
      mon_cnt    = 0;
    end
    else
    begin
      if (brk === 1'b1)
      begin
        check_brk(brk_pending > 0, brk);
        if (brk_pending > 0)
          brk_pending--;
      end
      if (!mon_active)
      begin
        mon_active = tx_prev && !tx;  // start edge
        mon_cnt    = 0;
      end
      else
      begin
        mon_cnt++;
        if (mon_cnt == HALF_BIT)
          check_level("tx start bit", 1'b0, tx);
        else if (mon_cnt == HALF_BIT + 9 * CLK_PER_BIT)
        begin
          check_level("tx stop bit", 1'b1, tx);
          if (exp_q.size() == 0)
          begin
            $display("tx sent %02h at %0d ns but no echo was expected", mon_byte, $time);
            err_count++;
          end
          else
            check_byte("tx data", exp_q.pop_front(), mon_byte);
          mon_active = 1'b0;
        end
        else if (mon_cnt > HALF_BIT && (mon_cnt - HALF_BIT) % CLK_PER_BIT == 0)
          mon_byte = {tx, mon_byte[7:1]};  // data bits, lsb first
      end
      tx_prev = tx;
    end
  end

  initial
  begin
    rst           = 1'b1;
    rx            = 1'b1;  // line idle
    lfsr          = LFSR_SEED;
    brk_pending   = 0;
    err_count     = 0;
    check_count   = 0;
    test_count    = 0;
    test_fails    = 0;
    test_err_base = 0;
    test_num      = 0;
    repeat (8) @(posedge clk);
    #2;
    rst = 1'b0;
    begin_test(1);  // idle outputs after reset
    repeat (20)
    begin
      @(negedge clk);
      check_level("tx", 1'b1, tx);
      check_brk(1'b0, brk);
    end
    @(posedge clk);
    #2;
    report_test();
    run_file();
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             test_count, test_fails, check_count, err_count);
    if (err_count == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

// File: design/uart_echo.sv
`timescale 1ns/10ps

// uart echo top
// rx -> fifo -> echo consumer -> tx
module uart_echo import uart_pkg::*; (
  input  logic clk,
  input  logic rst,
  input  logic rx,   // idles high
  output logic tx,   // idles high
  output logic brk   // pulse per received break
);

  rx_item_t rx_item;    // receiver output
  logic     rx_wr;
  rx_item_t head;       // fifo head
  logic     not_empty;
  logic     pop;
  byte_t    tx_data;    // consumer to transmitter
  logic     tx_wr;
  logic     busy;

  serial_rx serial_rx_i (
    .clk  (clk),
    .rst  (rst),
    .rx   (rx),
    .item (rx_item),
    .wr   (rx_wr)
  );

  rx_fifo rx_fifo_i (
    .clk       (clk),
    .rst       (rst),
    .wr        (rx_wr),
    .item      (rx_item),
    .pop       (pop),
    .head      (head),
    .not_empty (not_empty)
  );

  echo_ctrl echo_ctrl_i (
    .clk       (clk),
    .rst       (rst),
    .head      (head),
    .not_empty (not_empty),
    .pop       (pop),
    .tx_data   (tx_data),
    .wr        (tx_wr),
    .busy      (busy),
    .brk       (brk)
  );

  serial_tx serial_tx_i (
    .clk     (clk),
    .rst     (rst),
    .tx_data (tx_data),
    .wr      (tx_wr),
    .busy    (busy),
    .tx      (tx)
  );

endmodule

// File: design/serial_tx.sv
`timescale 1ns/10ps

// uart transmitter
// start bit, 8 data bits lsb first, stop bit; busy for the whole frame
module serial_tx import uart_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  byte_t tx_data,  // sampled with wr
  input  logic  wr,       // only while busy is low
  output logic  busy,
  output logic  tx        // serial out, idles high
);

  logic [9:0]           shreg;    // frame, bit 0 on the line
  logic [BIT_CNT_W-1:0] cnt;      // clocks within current bit
  logic [3:0]           bit_idx;  // 0 start .. 9 stop
  logic                 bit_end;

  assign bit_end = (cnt == BIT_CNT_W'(CLK_PER_BIT - 1));
  assign tx      = shreg[0];  // straight from a flop

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      shreg   <= '1;  // line idle high
      cnt     <= '0;
      bit_idx <= '0;
      busy    <= 1'b0;
    end
    else if (!busy)
    begin
      cnt     <= '0;
      bit_idx <= '0;
      if (wr)
      begin
        shreg <= {1'b1, tx_data, 1'b0};  // stop, data, start
        busy  <= 1'b1;
      end
    end
    else
    begin
      cnt <= cnt + 1'b1;
      if (bit_end)
      begin
        cnt     <= '0;
        shreg   <= {1'b1, shreg[9:1]};  // refill with idle level
        bit_idx <= bit_idx + 1'b1;
        if (bit_idx == 4'd9)
          busy <= 1'b0;  // stop bit done
      end
    end
  end

endmodule

// File: design/echo_ctrl.sv
`timescale 1ns/10ps

// echo consumer
// pops items, swaps letter case, feeds tx, pulses brk on breaks
module echo_ctrl import uart_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  rx_item_t head,       // oldest fifo item
  input  logic     not_empty,
  output logic     pop,        // take head this cycle
  output byte_t    tx_data,    // byte for the transmitter
  output logic     wr,         // one-cycle tx request
  input  logic     busy,       // tx frame in progress
  output logic     brk         // one-cycle break report
);

  logic  pending;  // wr issued, busy not yet seen
  logic  is_letter;
  byte_t echo_byte;

  // letters only, 'A'..'Z' and 'a'..'z'
  assign is_letter = ((head.data >= "A") && (head.data <= "Z"))
                  || ((head.data >= "a") && (head.data <= "z"));
  assign echo_byte = is_letter ? (head.data ^ 8'h20) : head.data;  // bit 5 is case

  // take an item only when tx can accept it next cycle
  assign pop = not_empty && !busy && !pending;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wr      <= 1'b0;
      brk     <= 1'b0;
      pending <= 1'b0;
    end
    else
    begin
      wr  <= pop && !head.brk;
      brk <= pop && head.brk;  // break is reported, never echoed
      if (busy)
        pending <= 1'b0;       // tx has the byte
      else if (pop && !head.brk)
        pending <= 1'b1;
    end
  end

  // data register
  always_ff @(posedge clk)
  begin
    if (pop && !head.brk)
      tx_data <= echo_byte;
  end

  // pending flag keeps a second write out of a running frame
  a_wr_idle: assert property (@(posedge clk) disable iff (rst) wr |-> !busy);

endmodule

// File: design/rx_fifo.sv
`timescale 1ns/10ps

// small synchronous fifo for received items
// head is the oldest entry, valid while not_empty
module rx_fifo import uart_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     wr,         // push item this cycle
  input  rx_item_t item,
  input  logic     pop,        // drop head, only while not_empty
  output rx_item_t head,
  output logic     not_empty
);

  rx_item_t             mem [FIFO_DEPTH];
  logic [FIFO_AW-1:0]   wr_ptr;
  logic [FIFO_AW-1:0]   rd_ptr;
  logic [FIFO_AW:0]     count;   // one extra bit to hold full
  logic                 full;

  assign head      = mem[rd_ptr];  // comb read of oldest entry
  assign not_empty = (count != '0);
  assign full      = (count == (FIFO_AW + 1)'(FIFO_DEPTH));

  // storage, no reset
  always_ff @(posedge clk)
  begin
    if (wr)
      mem[wr_ptr] <= item;
  end

  // pointers and occupancy
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (wr)
        wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({wr, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither
      endcase
    end
  end

  // consumer only pops what is there
  a_no_underflow: assert property (@(posedge clk) disable iff (rst) pop |-> not_empty);

  // tx drains as fast as rx fills, so this never fires in normal use
  a_no_overflow: assert property (@(posedge clk) disable iff (rst) wr |-> !full);

endmodule

// File: design/serial_rx.sv
`timescale 1ns/10ps

// uart receiver
// samples mid-bit after a 2-flop sync, emits byte or break items
module serial_rx import uart_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     rx,    // serial in, idles high
  output rx_item_t item,  // valid while wr is high
  output logic     wr     // one-cycle strobe, no back-pressure
);

  typedef enum logic [2:0] {
    IDLE,
    START,
    DATA,
    STOP,
    WAIT_HIGH
  } state_t;

  state_t               state;
  logic                 rx_meta;  // first sync flop
  logic                 rx_sync;  // synchronized line
  logic                 rx_prev;  // for falling edge detect
  logic [BIT_CNT_W-1:0] cnt;      // clocks within current bit
  logic [2:0]           bit_idx;  // data bit number
  byte_t                shreg;    // data bits, lsb arrives first
  logic                 half_hit;
  logic                 full_hit;

  assign half_hit = (cnt == BIT_CNT_W'(HALF_BIT - 1));
  assign full_hit = (cnt == BIT_CNT_W'(CLK_PER_BIT - 1));

  // control path
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
      state   <= IDLE;
      cnt     <= '0;
      bit_idx <= '0;
      wr      <= 1'b0;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
      wr      <= 1'b0;  // strobe by default
      cnt     <= cnt + 1'b1;
      case (state)
        IDLE:
        begin
          cnt <= '0;
          if (rx_prev && !rx_sync)
            state <= START;  // falling edge
        end
        START:
          if (half_hit)
          begin
            cnt     <= '0;
            bit_idx <= '0;
            state   <= rx_sync ? IDLE : DATA;  // high again means glitch
          end
        DATA:
          if (full_hit)
          begin
            cnt     <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7)
              state <= STOP;
          end
        STOP:
          if (full_hit)
          begin
            cnt <= '0;
            if (rx_sync)
            begin
              wr    <= 1'b1;  // good frame
              state <= IDLE;
            end
            else
            begin
              wr    <= (shreg == '0);  // break, else framing error dropped
              state <= WAIT_HIGH;
            end
          end
        WAIT_HIGH:
        begin
          cnt <= '0;
          if (rx_sync)
            state <= IDLE;  // line released, arm again
        end
        default: state <= IDLE;
      endcase
    end
  end

  // payload, no reset needed
  always_ff @(posedge clk)
  begin
    if (state == DATA && full_hit)
      shreg <= {rx_sync, shreg[7:1]};  // shift in from the top
    if (state == STOP && full_hit)
    begin
      item.brk  <= !rx_sync;
      item.data <= shreg;
    end
  end

  // items are at least a frame apart
  a_wr_single: assert property (@(posedge clk) disable iff (rst) wr |=> !wr);

endmodule

// File: design/uart_pkg.sv
// shared timing, sizes and item types for the uart echo path

package uart_pkg;

  // serial bit timing
  localparam int CLK_PER_BIT = 16;                 // even, 4 or more
  localparam int HALF_BIT    = CLK_PER_BIT / 2;    // offset to mid-bit
  localparam int BIT_CNT_W   = $clog2(CLK_PER_BIT); // bit-time counter width

  // receive buffer
  localparam int FIFO_DEPTH = 8;                   // entries, power of two
  localparam int FIFO_AW    = $clog2(FIFO_DEPTH);  // pointer width

  // one data byte on the wire
  typedef logic [7:0] byte_t;

  // received item, receiver -> fifo -> consumer
  // brk set means a line break, data is then all zero
  typedef struct packed {
    logic  brk;   // break seen instead of a byte
    byte_t data;  // received byte, lsb first on the wire
  } rx_item_t;

endpackage
